// ==== source/riscv_pkg.sv ====
// architectural widths, privilege levels and exception layout shared by the trace logic
package riscv_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  // data and cause width
  localparam int unsigned XLEN = 64;

  // virtual address width of a pc
  localparam int unsigned VLEN = 64;

  // raw instruction word
  localparam int unsigned INSN_W = 32;

  // interrupt flag sits in the top bit of the cause
  localparam int unsigned IRQ_BIT = XLEN - 1;

  // ------------------------------
  // privilege levels
  // ------------------------------
  // encoding as in the privileged spec, level 2 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // ------------------------------
  // exception info
  // ------------------------------
  // cause carries the interrupt flag at IRQ_BIT,
  // tval holds the faulting value or the instruction word
  typedef struct packed {
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] tval;
    logic            valid;
  } exception_t;

endpackage

// ==== source/trace_pkg.sv ====
// commit entry and trace record layouts plus sizing of the commit trace path
package trace_pkg;

  // ------------------------------
  // sizing
  // ------------------------------
  // instructions retired per cycle at most
  localparam int unsigned NR_COMMIT_PORTS = 2;

  // entries in each per-port pc queue
  localparam int unsigned PC_QUEUE_DEPTH = 16;

  // port index width, kept at least one bit wide
  localparam int unsigned PORT_IDX_W =
      (NR_COMMIT_PORTS > 1) ? $clog2(NR_COMMIT_PORTS) : 1;

  // ------------------------------
  // commit side
  // ------------------------------
  // what the commit stage hands over per port
  // ex.tval carries the instruction word for retired instructions
  typedef struct packed {
    logic [riscv_pkg::VLEN-1:0] pc;
    riscv_pkg::exception_t      ex;
  } commit_entry_t;

  // ------------------------------
  // trace side
  // ------------------------------
  // one record per commit port and cycle
  // at most one of valid, exception and interrupt is set
  typedef struct packed {
    logic                         valid;
    logic [riscv_pkg::VLEN-1:0]   iaddr;
    logic [riscv_pkg::INSN_W-1:0] insn;
    riscv_pkg::priv_lvl_t         priv;
    logic                         exception;
    logic                         interrupt;
    logic [riscv_pkg::XLEN-1:0]   cause;
    logic [riscv_pkg::INSN_W-1:0] tval;
  } trace_port_t;

  // record layout summary
  //   valid      retired without exception
  //   exception  synchronous trap on this commit
  //   interrupt  asynchronous trap taken on this commit
  //   iaddr      pc of the committing instruction
  //   insn/tval  low word of the exception tval
  //   priv       privilege level sampled at commit
  //   cause      full trap cause including the interrupt flag

endpackage

// ==== source/commit_classifier.sv ====
// classifies each commit port into a registered trace record and a pc queue push
`timescale 1ns/10ps

module commit_classifier (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  commit_ack_i,
  input  trace_pkg::commit_entry_t [trace_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  riscv_pkg::priv_lvl_t                                   priv_lvl_i,
  output trace_pkg::trace_port_t [trace_pkg::NR_COMMIT_PORTS-1:0]   trace_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  push_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::VLEN-1:0] push_pc_o
);

  // ------------------------------
  // record state
  // ------------------------------
  logic [trace_pkg::NR_COMMIT_PORTS-1:0] valid_q;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0] exc_q;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0] irq_q;

  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::VLEN-1:0]   iaddr_q;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::INSN_W-1:0] insn_q;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::XLEN-1:0]   cause_q;
  riscv_pkg::priv_lvl_t                                         priv_q;

  // flags per port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      exc_q   <= '0;
      irq_q   <= '0;
    end else begin
      for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
        valid_q[i] <= commit_ack_i[i] & ~commit_instr_i[i].ex.valid;
        // interrupt flag in the cause splits traps into the two kinds
        exc_q[i]   <= commit_ack_i[i] & commit_instr_i[i].ex.valid &
                      ~commit_instr_i[i].ex.cause[riscv_pkg::IRQ_BIT];
        irq_q[i]   <= commit_ack_i[i] & commit_instr_i[i].ex.valid &
                      commit_instr_i[i].ex.cause[riscv_pkg::IRQ_BIT];
      end
    end
  end

  // payload captured every cycle, only meaningful with a flag set
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
      iaddr_q[i] <= commit_instr_i[i].pc;
      insn_q[i]  <= commit_instr_i[i].ex.tval[riscv_pkg::INSN_W-1:0];
      cause_q[i] <= commit_instr_i[i].ex.cause;
    end
    priv_q <= priv_lvl_i;
  end

  // ------------------------------
  // outputs
  // ------------------------------
  always_comb begin
    for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
      trace_o[i].valid     = valid_q[i];
      trace_o[i].iaddr     = iaddr_q[i];
      trace_o[i].insn      = insn_q[i];
      trace_o[i].priv      = priv_q;
      trace_o[i].exception = exc_q[i];
      trace_o[i].interrupt = irq_q[i];
      trace_o[i].cause     = cause_q[i];
      trace_o[i].tval      = insn_q[i];
    end
  end

  // retired pcs go straight into the queue at the sampling edge
  for (genvar i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin : gen_push
    assign push_o[i]    = commit_ack_i[i] & ~commit_instr_i[i].ex.valid;
    assign push_pc_o[i] = commit_instr_i[i].pc;
  end

endmodule

// ==== source/pc_fifo.sv ====
// circular pc queue for one commit port, written by the classifier and drained by the arbiter
`timescale 1ns/10ps

module pc_fifo #(
  parameter int unsigned DEPTH = trace_pkg::PC_QUEUE_DEPTH
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       push_i,
  input  logic [riscv_pkg::VLEN-1:0] pc_i,
  input  logic                       pop_i,
  output logic [riscv_pkg::VLEN-1:0] pc_o,
  output logic                       empty_o
);

  // ------------------------------
  // storage and pointers
  // ------------------------------
  logic [riscv_pkg::VLEN-1:0] mem_q [DEPTH];

  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;

  logic full;
  logic push_ok;
  logic pop_ok;

  assign empty_o = (count_q == '0);
  assign full    = (count_q == DEPTH);

  // a pop on an empty queue is dropped
  assign pop_ok  = pop_i & ~empty_o;
  // push on a full queue only lands if a pop frees the slot
  assign push_ok = push_i & (~full | pop_ok);

  // head of the queue
  assign pc_o = mem_q[rd_ptr_q];

  // ------------------------------
  // write side
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= pc_i;
    end
  end

  // ------------------------------
  // pointer and count update
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        // explicit wrap, depth need not be a power of two
        if (wr_ptr_q == DEPTH - 1) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end

      if (pop_ok) begin
        if (rd_ptr_q == DEPTH - 1) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end

      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== source/pc_rr_arbiter.sv ====
// round-robin merge of the per-port pc queues into one always-accepted pc stream
`timescale 1ns/10ps

module pc_rr_arbiter (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  empty_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::VLEN-1:0] pc_i,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  pop_o,
  output logic                                                   pc_valid_o,
  output logic [riscv_pkg::VLEN-1:0]                             pc_o,
  output logic [trace_pkg::PORT_IDX_W-1:0]                       pc_port_o
);

  // port index base + off, wrapped around the port count
  function automatic logic [trace_pkg::PORT_IDX_W-1:0] wrap_idx(
    input int unsigned base,
    input int unsigned off
  );
    int unsigned sum;
    sum = (base + off) % trace_pkg::NR_COMMIT_PORTS;
    return sum[trace_pkg::PORT_IDX_W-1:0];
  endfunction

  // ------------------------------
  // grant search
  // ------------------------------
  // first port to look at in this cycle
  logic [trace_pkg::PORT_IDX_W-1:0] rr_q;
  logic [trace_pkg::PORT_IDX_W-1:0] sel_idx;
  logic                             any_req;

  always_comb begin
    sel_idx = rr_q;
    any_req = 1'b0;
    // walk from the pointer, first non-empty queue wins
    for (int unsigned k = 0; k < trace_pkg::NR_COMMIT_PORTS; k++) begin
      if (!any_req && !empty_i[wrap_idx(rr_q, k)]) begin
        any_req = 1'b1;
        sel_idx = wrap_idx(rr_q, k);
      end
    end
  end

  // ------------------------------
  // merged stream
  // ------------------------------
  // sink never stalls, so a grant pops right away
  always_comb begin
    pop_o = '0;
    if (any_req) begin
      pop_o[sel_idx] = 1'b1;
    end
  end

  assign pc_valid_o = any_req;
  assign pc_o       = pc_i[sel_idx];
  assign pc_port_o  = sel_idx;

  // pointer moves past the granted port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (any_req) begin
      rr_q <= wrap_idx(sel_idx, 1);
    end
  end

endmodule

// ==== source/commit_trace.sv ====
// commit trace top level, per-port trace records plus the merged stream of retired pcs
`timescale 1ns/10ps

module commit_trace (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                   commit_ack_i,
  input  trace_pkg::commit_entry_t [trace_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  riscv_pkg::priv_lvl_t                                    priv_lvl_i,
  output trace_pkg::trace_port_t [trace_pkg::NR_COMMIT_PORTS-1:0]   trace_o,
  output logic                                                    pc_valid_o,
  output logic [riscv_pkg::VLEN-1:0]                              pc_o,
  output logic [trace_pkg::PORT_IDX_W-1:0]                        pc_port_o
);

  // ------------------------------
  // internal wiring
  // ------------------------------
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      push;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::VLEN-1:0] push_pc;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      pop;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      empty;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::VLEN-1:0] head_pc;

  // trace records and queue pushes
  commit_classifier i_commit_classifier (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_ack_i   ( commit_ack_i   ),
    .commit_instr_i ( commit_instr_i ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .trace_o        ( trace_o        ),
    .push_o         ( push           ),
    .push_pc_o      ( push_pc        )
  );

  // one pc queue per commit port
  for (genvar i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin : gen_pc_fifo
    pc_fifo #(
      .DEPTH ( trace_pkg::PC_QUEUE_DEPTH )
    ) i_pc_fifo (
      .clk_i   ( clk_i      ),
      .rst_ni  ( rst_ni     ),
      .push_i  ( push[i]    ),
      .pc_i    ( push_pc[i] ),
      .pop_i   ( pop[i]     ),
      .pc_o    ( head_pc[i] ),
      .empty_o ( empty[i]   )
    );
  end

  // merge the queue heads
  pc_rr_arbiter i_pc_rr_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .empty_i    ( empty      ),
    .pc_i       ( head_pc    ),
    .pop_o      ( pop        ),
    .pc_valid_o ( pc_valid_o ),
    .pc_o       ( pc_o       ),
    .pc_port_o  ( pc_port_o  )
  );

endmodule

// ==== verif/commit_trace_chk.sv ====
// bound checker for commit_trace, reference pc queues and concurrent assertions on the outputs
`timescale 1ns/10ps

module commit_trace_chk (
  input logic                                                      clk_i,
  input logic                                                      rst_ni,
  input logic [trace_pkg::NR_COMMIT_PORTS-1:0]                     commit_ack_i,
  input trace_pkg::commit_entry_t [trace_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input riscv_pkg::priv_lvl_t                                      priv_lvl_i,
  input trace_pkg::trace_port_t [trace_pkg::NR_COMMIT_PORTS-1:0]   trace_o,
  input logic                                                      pc_valid_o,
  input logic [riscv_pkg::VLEN-1:0]                                pc_o,
  input logic [trace_pkg::PORT_IDX_W-1:0]                          pc_port_o
);

  localparam int unsigned REC_W = riscv_pkg::VLEN + 2 * riscv_pkg::INSN_W + 2;

  // raised by any failing assertion, watched by the testbench
  logic fail_flag = 1'b0;

  // ------------------------------
  // expected record content
  // ------------------------------
  // flags are {valid, exception, interrupt}
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][2:0]       exp_flags;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][2:0]       out_flags;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][REC_W-1:0] exp_rec;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][REC_W-1:0] out_rec;

  always_comb begin
    for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
      out_flags[i] = {trace_o[i].valid, trace_o[i].exception, trace_o[i].interrupt};
      out_rec[i]   = {trace_o[i].iaddr, trace_o[i].insn, trace_o[i].tval, trace_o[i].priv};
      // insn and tval both come from the low word of tval
      exp_rec[i]   = {commit_instr_i[i].pc,
                      commit_instr_i[i].ex.tval[riscv_pkg::INSN_W-1:0],
                      commit_instr_i[i].ex.tval[riscv_pkg::INSN_W-1:0], priv_lvl_i};
      if (!commit_ack_i[i]) begin
        exp_flags[i] = 3'b000;
      end else if (!commit_instr_i[i].ex.valid) begin
        exp_flags[i] = 3'b100;
      end else if (commit_instr_i[i].ex.cause[riscv_pkg::IRQ_BIT]) begin
        exp_flags[i] = 3'b001;
      end else begin
        exp_flags[i] = 3'b010;
      end
    end
  end

  // ------------------------------
  // reference pc queues
  // ------------------------------
  logic [riscv_pkg::VLEN-1:0]                                 ref_q [trace_pkg::NR_COMMIT_PORTS][$];
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      ref_nonempty;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::VLEN-1:0] ref_head;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
        ref_q[i].delete();
      end
      ref_nonempty <= '0;
      ref_head     <= '0;
    end else begin
      // presented pc leaves first, then this edge's retired pcs enter
      if (pc_valid_o && ref_q[pc_port_o].size() > 0) begin
        void'(ref_q[pc_port_o].pop_front());
      end
      for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
        if (commit_ack_i[i] && !commit_instr_i[i].ex.valid) begin
          ref_q[i].push_back(commit_instr_i[i].pc);
        end
        ref_nonempty[i] <= (ref_q[i].size() > 0);
        ref_head[i]     <= (ref_q[i].size() > 0) ? ref_q[i][0] : '0;
      end
    end
  end

  // ------------------------------
  // assertions
  // ------------------------------
  a_reset_quiet: assert property (@(posedge clk_i)
    (!rst_ni || $rose(rst_ni)) |-> (out_flags == '0) && !pc_valid_o)
    else begin
      $error("[ERROR] reset_quiet expected 0 actual flags %b pc_valid %b",
             $sampled(out_flags), $sampled(pc_valid_o));
      fail_flag = 1'b1;
    end

  a_pc_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_valid_o == (|ref_nonempty))
    else begin
      $error("[ERROR] pc_valid expected %b actual %b",
             $sampled(|ref_nonempty), $sampled(pc_valid_o));
      fail_flag = 1'b1;
    end

  a_pc_stream: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_valid_o |-> pc_o == ref_head[pc_port_o])
    else begin
      $error("[ERROR] pc_stream expected %h actual %h",
             $sampled(ref_head[pc_port_o]), $sampled(pc_o));
      fail_flag = 1'b1;
    end

  // two ports, so a busy pair must alternate
  a_round_robin: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pc_valid_o && (&ref_nonempty)) ##1 (pc_valid_o && (&ref_nonempty))
    |-> pc_port_o != $past(pc_port_o))
    else begin
      $error("[ERROR] round_robin expected %0d actual %0d",
             $past(pc_port_o) + 1'b1, $sampled(pc_port_o));
      fail_flag = 1'b1;
    end

  for (genvar i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin : gen_port_chk
    a_flags: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_flags[i] == $past(exp_flags[i]))
      else begin
        $error("[ERROR] record_flags port %0d expected %b actual %b",
               i, $past(exp_flags[i]), $sampled(out_flags[i]));
        fail_flag = 1'b1;
      end

    a_record: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $past(exp_flags[i] == 3'b100) |-> out_rec[i] == $past(exp_rec[i]))
      else begin
        $error("[ERROR] retired_record port %0d expected %h actual %h",
               i, $past(exp_rec[i]), $sampled(out_rec[i]));
        fail_flag = 1'b1;
      end

    a_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $past(exp_flags[i][1:0] != 2'b00) |-> trace_o[i].cause == $past(commit_instr_i[i].ex.cause))
      else begin
        $error("[ERROR] trap_cause port %0d expected %h actual %h",
               i, $past(commit_instr_i[i].ex.cause), $sampled(trace_o[i].cause));
        fail_flag = 1'b1;
      end
  end

endmodule

// ==== verif/commit_trace_tb.sv ====
// testbench for commit_trace, random commit bursts with idle gaps drained through the pc stream
`timescale 1ns/10ps

module commit_trace_tb;

  localparam int unsigned CLK_PERIOD   = 40;
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned NR_BURSTS    = 12;
  // a dense burst grows each queue by about half its length
  localparam int unsigned BURST_LEN    = 20;
  localparam int unsigned GAP_LEN      = 24;
  localparam int unsigned STIM_CYCLES  = RESET_CYCLES + NR_BURSTS * (BURST_LEN + GAP_LEN);
  localparam int unsigned WATCHDOG_CYCLES =
      STIM_CYCLES + trace_pkg::NR_COMMIT_PORTS * trace_pkg::PC_QUEUE_DEPTH + 100;

  logic                                                    clk_i;
  logic                                                    rst_ni;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                   commit_ack_i;
  trace_pkg::commit_entry_t [trace_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i;
  riscv_pkg::priv_lvl_t                                    priv_lvl_i;
  trace_pkg::trace_port_t [trace_pkg::NR_COMMIT_PORTS-1:0]   trace_o;
  logic                                                    pc_valid_o;
  logic [riscv_pkg::VLEN-1:0]                              pc_o;
  logic [trace_pkg::PORT_IDX_W-1:0]                        pc_port_o;

  logic [31:0] lcg_state;

  commit_trace UUT (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_ack_i   ( commit_ack_i   ),
    .commit_instr_i ( commit_instr_i ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .trace_o        ( trace_o        ),
    .pc_valid_o     ( pc_valid_o     ),
    .pc_o           ( pc_o           ),
    .pc_port_o      ( pc_port_o      )
  );

  bind commit_trace commit_trace_chk i_chk (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // dense cycles retire mostly, sparse cycles only trap and let the queues drain
  task automatic drive_commits(input bit dense);
    logic [31:0]              r;
    trace_pkg::commit_entry_t e;
    @(posedge clk_i);
    for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
      r           = next_rand();
      e.pc        = {next_rand(), next_rand()};
      e.ex.tval   = {next_rand(), next_rand()};
      // top bit picks interrupt or exception
      e.ex.cause  = {r[4], 58'd0, r[9:5]};
      e.ex.valid  = dense ? (r[3:0] == 4'd0) : 1'b1;
      commit_instr_i[i] <= e;
      commit_ack_i[i]   <= dense ? (r[15:13] != 3'd0) : (r[15:13] == 3'd0);
    end
    r = next_rand();
    case (r[21:20])
      2'b00:   priv_lvl_i <= riscv_pkg::PRIV_LVL_U;
      2'b01:   priv_lvl_i <= riscv_pkg::PRIV_LVL_S;
      default: priv_lvl_i <= riscv_pkg::PRIV_LVL_M;
    endcase
  endtask

  initial begin
    lcg_state      = 32'd9;
    rst_ni         = 1'b0;
    commit_ack_i   = '0;
    commit_instr_i = '0;
    priv_lvl_i     = riscv_pkg::PRIV_LVL_M;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int b = 0; b < NR_BURSTS; b++) begin
      repeat (BURST_LEN) drive_commits(1'b1);
      repeat (GAP_LEN) drive_commits(1'b0);
    end
    @(posedge clk_i);
    commit_ack_i <= '0;

    // wait for both queues to run dry
    do begin
      @(posedge clk_i);
    end while (pc_valid_o || (UUT.i_chk.ref_nonempty != '0));
    repeat (2) @(posedge clk_i);

    if (UUT.i_chk.fail_flag) begin
      $display("Result: FAILED");
      $fatal(1, "checker reported a failure");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  // ------------------------------
  // failure and timeout
  // ------------------------------
  initial begin
    wait (UUT.i_chk.fail_flag === 1'b1);
    $display("Result: FAILED");
    $fatal(1, "an assertion in the checker failed");
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Result: FAILED");
    $fatal(1, "timeout: stimulus and pc drain did not finish in time");
  end

endmodule

// ==== flist.f ====
source/riscv_pkg.sv
source/trace_pkg.sv
source/commit_classifier.sv
source/pc_fifo.sv
source/pc_rr_arbiter.sv
source/commit_trace.sv
verif/commit_trace_chk.sv
verif/commit_trace_tb.sv
